//--- hw/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address and data width of the fetch path
`define FETCH_XLEN 32

// Instruction memory depth in 32-bit words
`define FETCH_IMEM_WORDS 256

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// BTB geometry
`define FETCH_BTB_SETS 8
`define FETCH_BTB_WAYS 2

`endif

//--- hw/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

  // Field widths derived from the BTB geometry
  localparam int BTB_IDX_W = $clog2(`FETCH_BTB_SETS);
  localparam int BTB_TAG_W = `FETCH_XLEN - BTB_IDX_W - 2;
  localparam int BTB_WAY_W = (`FETCH_BTB_WAYS > 1) ? $clog2(`FETCH_BTB_WAYS) : 1;

  typedef logic [`FETCH_XLEN-1:0] addr_t;
  typedef logic [31:0]            instr_t;
  typedef logic [BTB_IDX_W-1:0]   btb_index_t;
  typedef logic [BTB_TAG_W-1:0]   btb_tag_t;
  typedef logic [BTB_WAY_W-1:0]   way_t;

  // Next-PC source in order of rising priority
  typedef enum logic [1:0] {
    PC_SEL_SEQUENTIAL,
    PC_SEL_PREDICTED,
    PC_SEL_REDIRECT
  } pc_sel_e;

endpackage

//--- hw/btb_way.sv
`timescale 1ns/100ps

`include "fetch_params.svh"

module btb_way (
  input  logic                 clk,
  input  logic                 rst_n,

  // Lookup side
  input  fetch_pkg::btb_index_t lookup_index,
  input  fetch_pkg::btb_tag_t  lookup_tag,
  output logic                 hit,
  output logic                 taken,
  output fetch_pkg::addr_t     target,

  // Update side
  input  fetch_pkg::btb_index_t upd_index,
  input  fetch_pkg::btb_tag_t  upd_tag,
  output logic                 match,
  input  logic                 we,
  input  fetch_pkg::addr_t     upd_target,
  input  logic                 upd_taken
);

  import fetch_pkg::*;

  logic [`FETCH_BTB_SETS-1:0] valid_q;
  btb_tag_t                   tag_q    [`FETCH_BTB_SETS];
  addr_t                      target_q [`FETCH_BTB_SETS];
  logic                       taken_q  [`FETCH_BTB_SETS];

  assign hit    = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
  assign taken  = taken_q[lookup_index];
  assign target = target_q[lookup_index];

  // Tells the steering logic this way already owns the update tag
  assign match = valid_q[upd_index] && (tag_q[upd_index] == upd_tag);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (we) begin
      valid_q[upd_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      tag_q[upd_index]    <= upd_tag;
      target_q[upd_index] <= upd_target;
      taken_q[upd_index]  <= upd_taken;
    end
  end

endmodule

//--- hw/btb.sv
`timescale 1ns/100ps

`include "fetch_params.svh"

module btb (
  input  logic             clk,
  input  logic             rst_n,

  // Lookup for the fetch pc
  input  fetch_pkg::addr_t pc,
  output logic             hit,
  output logic             taken,
  output fetch_pkg::addr_t target,

  // Update from EX
  input  logic             upd_valid,
  input  fetch_pkg::addr_t upd_pc,
  input  fetch_pkg::addr_t upd_target,
  input  logic             upd_taken
);

  import fetch_pkg::*;

  btb_index_t lookup_index;
  btb_tag_t   lookup_tag;
  btb_index_t upd_index;
  btb_tag_t   upd_tag;

  logic  [`FETCH_BTB_WAYS-1:0] way_hit;
  logic  [`FETCH_BTB_WAYS-1:0] way_taken;
  logic  [`FETCH_BTB_WAYS-1:0] way_match;
  addr_t                       way_target [`FETCH_BTB_WAYS];

  way_t rr_q [`FETCH_BTB_SETS];
  way_t upd_way;
  logic any_match;

  // Index sits just above the word offset, tag takes the rest
  assign lookup_index = pc[2 +: BTB_IDX_W];
  assign lookup_tag   = pc[`FETCH_XLEN-1 -: BTB_TAG_W];
  assign upd_index    = upd_pc[2 +: BTB_IDX_W];
  assign upd_tag      = upd_pc[`FETCH_XLEN-1 -: BTB_TAG_W];

  for (genvar w = 0; w < `FETCH_BTB_WAYS; w++) begin : g_way
    btb_way u_way (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_index (lookup_index),
      .lookup_tag   (lookup_tag),
      .hit          (way_hit[w]),
      .taken        (way_taken[w]),
      .target       (way_target[w]),
      .upd_index    (upd_index),
      .upd_tag      (upd_tag),
      .match        (way_match[w]),
      .we           (upd_valid && (upd_way == way_t'(w))),
      .upd_target   (upd_target),
      .upd_taken    (upd_taken)
    );
  end

  // Existing entry is rewritten in place, otherwise the set's victim
  always_comb begin
    upd_way   = rr_q[upd_index];
    any_match = 1'b0;
    for (int i = `FETCH_BTB_WAYS - 1; i >= 0; i--) begin
      if (way_match[i]) begin
        upd_way   = way_t'(i);
        any_match = 1'b1;
      end
    end
  end

  // Round-robin pointer moves only when a new entry is allocated
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int s = 0; s < `FETCH_BTB_SETS; s++) begin
        rr_q[s] <= '0;
      end
    end else if (upd_valid && !any_match) begin
      if (rr_q[upd_index] == way_t'(`FETCH_BTB_WAYS - 1)) begin
        rr_q[upd_index] <= '0;
      end else begin
        rr_q[upd_index] <= rr_q[upd_index] + way_t'(1);
      end
    end
  end

  // At most one way holds a given tag
  always_comb begin
    hit    = 1'b0;
    taken  = 1'b0;
    target = '0;
    for (int i = 0; i < `FETCH_BTB_WAYS; i++) begin
      if (way_hit[i]) begin
        hit    = 1'b1;
        taken  = way_taken[i];
        target = way_target[i];
      end
    end
  end

endmodule

//--- hw/imem.sv
`timescale 1ns/100ps

`include "fetch_params.svh"

module imem (
  input  logic              clk,

  // Fetch read port
  input  logic              ren,
  input  fetch_pkg::addr_t  raddr,
  output fetch_pkg::instr_t rdata,

  // Load port
  input  logic              we,
  input  fetch_pkg::addr_t  waddr,
  input  fetch_pkg::instr_t wdata
);

  import fetch_pkg::*;

  localparam int WORD_IDX_W = $clog2(`FETCH_IMEM_WORDS);

  typedef logic [WORD_IDX_W-1:0] word_idx_t;

  instr_t    mem [`FETCH_IMEM_WORDS];
  word_idx_t rd_idx;
  word_idx_t wr_idx;

  // Word addressing drops the byte offset
  assign rd_idx = raddr[2 +: WORD_IDX_W];
  assign wr_idx = waddr[2 +: WORD_IDX_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wr_idx] <= wdata;
    end
  end

  // Registered read that holds its output while ren is low
  always_ff @(posedge clk) begin
    if (ren) begin
      rdata <= mem[rd_idx];
    end
  end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/100ps

`include "fetch_params.svh"

module fetch_stage (
  input  logic             clk,
  input  logic             rst_n,

  // Hazard control and redirect from EX
  input  logic             stall,
  input  logic             redirect_valid,
  input  fetch_pkg::addr_t redirect_target,

  // BTB lookup results for the current pc
  input  logic             btb_hit,
  input  logic             btb_taken,
  input  fetch_pkg::addr_t btb_target,
  output fetch_pkg::addr_t pc,

  // Instruction memory read port
  output logic             imem_ren,
  output fetch_pkg::addr_t imem_raddr,
  input  fetch_pkg::instr_t imem_rdata,

  // IF/ID outputs to decode
  output logic             valid_id,
  output fetch_pkg::instr_t instr_id,
  output fetch_pkg::addr_t pc_id,
  output fetch_pkg::addr_t pc_plus4_id,
  output logic             btb_hit_id,
  output logic             btb_pred_taken_id,
  output fetch_pkg::addr_t btb_target_id
);

  import fetch_pkg::*;

  pc_sel_e pc_sel;
  addr_t   pc_next;
  addr_t   pc_plus4;

  assign pc_plus4 = pc + addr_t'(4);

  // Redirect beats prediction, prediction beats sequential
  always_comb begin
    if (redirect_valid) begin
      pc_sel = PC_SEL_REDIRECT;
    end else if (btb_hit && btb_taken) begin
      pc_sel = PC_SEL_PREDICTED;
    end else begin
      pc_sel = PC_SEL_SEQUENTIAL;
    end
  end

  always_comb begin
    case (pc_sel)
      PC_SEL_REDIRECT:  pc_next = redirect_target;
      PC_SEL_PREDICTED: pc_next = btb_target;
      default:          pc_next = pc_plus4;
    endcase
  end

  // A redirect moves the pc even during a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `FETCH_RESET_PC;
    end else if (redirect_valid || !stall) begin
      pc <= pc_next;
    end
  end

  // Memory reads the current pc, so the word lands together with pc_id
  assign imem_ren   = !stall;
  assign imem_raddr = pc;
  assign instr_id   = imem_rdata;

  // IF/ID control bits are flushed by a redirect
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_id          <= 1'b0;
      btb_hit_id        <= 1'b0;
      btb_pred_taken_id <= 1'b0;
    end else if (redirect_valid) begin
      valid_id          <= 1'b0;
      btb_hit_id        <= 1'b0;
      btb_pred_taken_id <= 1'b0;
    end else if (!stall) begin
      valid_id          <= 1'b1;
      btb_hit_id        <= btb_hit;
      btb_pred_taken_id <= btb_hit && btb_taken;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_id         <= pc;
      pc_plus4_id   <= pc_plus4;
      btb_target_id <= btb_target;
    end
  end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/100ps

module fetch_top (
  input  logic              clk,
  input  logic              rst_n,

  // EX stage control
  input  logic              stall,
  input  logic              redirect_valid,
  input  fetch_pkg::addr_t  redirect_target,

  // BTB update from EX
  input  logic              btb_upd_valid,
  input  fetch_pkg::addr_t  btb_upd_pc,
  input  fetch_pkg::addr_t  btb_upd_target,
  input  logic              btb_upd_taken,

  // Memory load port
  input  logic              imem_we,
  input  fetch_pkg::addr_t  imem_waddr,
  input  fetch_pkg::instr_t imem_wdata,

  // To decode
  output logic              valid_id,
  output fetch_pkg::instr_t instr_id,
  output fetch_pkg::addr_t  pc_id,
  output fetch_pkg::addr_t  pc_plus4_id,
  output logic              btb_hit_id,
  output logic              btb_pred_taken_id,
  output fetch_pkg::addr_t  btb_target_id
);

  import fetch_pkg::*;

  addr_t  pc;
  logic   btb_hit;
  logic   btb_taken;
  addr_t  btb_target;
  logic   imem_ren;
  addr_t  imem_raddr;
  instr_t imem_rdata;

  fetch_stage u_fetch_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .stall             (stall),
    .redirect_valid    (redirect_valid),
    .redirect_target   (redirect_target),
    .btb_hit           (btb_hit),
    .btb_taken         (btb_taken),
    .btb_target        (btb_target),
    .pc                (pc),
    .imem_ren          (imem_ren),
    .imem_raddr        (imem_raddr),
    .imem_rdata        (imem_rdata),
    .valid_id          (valid_id),
    .instr_id          (instr_id),
    .pc_id             (pc_id),
    .pc_plus4_id       (pc_plus4_id),
    .btb_hit_id        (btb_hit_id),
    .btb_pred_taken_id (btb_pred_taken_id),
    .btb_target_id     (btb_target_id)
  );

  imem u_imem (
    .clk   (clk),
    .ren   (imem_ren),
    .raddr (imem_raddr),
    .rdata (imem_rdata),
    .we    (imem_we),
    .waddr (imem_waddr),
    .wdata (imem_wdata)
  );

  btb u_btb (
    .clk        (clk),
    .rst_n      (rst_n),
    .pc         (pc),
    .hit        (btb_hit),
    .taken      (btb_taken),
    .target     (btb_target),
    .upd_valid  (btb_upd_valid),
    .upd_pc     (btb_upd_pc),
    .upd_target (btb_upd_target),
    .upd_taken  (btb_upd_taken)
  );

endmodule

//--- test/fetch_assert.sv
`timescale 1ns/100ps

module fetch_assert (
  input logic              clk,
  input logic              rst_n,
  input logic              stall,
  input logic              redirect_valid,
  input logic              valid_id,
  input fetch_pkg::instr_t instr_id,
  input fetch_pkg::addr_t  pc_id,
  input fetch_pkg::addr_t  pc_plus4_id,
  input logic              btb_hit_id,
  input logic              btb_pred_taken_id
);

  import fetch_pkg::*;

  int fail_count = 0;

  // A redirect edge flushes IF/ID
  flush_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
    redirect_valid |=> !valid_id)
    else begin
      $error("valid_id high in the cycle after a redirect");
      fail_count++;
    end

  hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
    (stall && !redirect_valid && valid_id) |=> $stable(valid_id) && $stable(instr_id)
      && $stable(pc_id) && $stable(pc_plus4_id) && $stable(btb_hit_id)
      && $stable(btb_pred_taken_id))
    else begin
      $error("IF/ID outputs changed across a stall");
      fail_count++;
    end

  pc_plus4_match: assert property (@(posedge clk) disable iff (!rst_n)
    valid_id |-> pc_plus4_id == addr_t'(pc_id + 32'd4))
    else begin
      $error("pc_plus4_id is not pc_id plus 4");
      fail_count++;
    end

endmodule

bind fetch_top fetch_assert u_fetch_assert (
  .clk               (clk),
  .rst_n             (rst_n),
  .stall             (stall),
  .redirect_valid    (redirect_valid),
  .valid_id          (valid_id),
  .instr_id          (instr_id),
  .pc_id             (pc_id),
  .pc_plus4_id       (pc_plus4_id),
  .btb_hit_id        (btb_hit_id),
  .btb_pred_taken_id (btb_pred_taken_id)
);

//--- test/fetch_tb.sv
`timescale 1ns/100ps

`include "fetch_params.svh"

module fetch_tb;

  import fetch_pkg::*;

  localparam int IDX_W   = $clog2(`FETCH_BTB_SETS);
  localparam int WORD_W  = $clog2(`FETCH_IMEM_WORDS);
  localparam int TIMEOUT = 50;

  typedef struct packed {
    logic  hit;
    logic  taken;
    addr_t target;
  } btb_res_t;

  typedef struct packed {
    addr_t    pc;
    btb_res_t btb;
  } fetch_exp_t;

  logic   clk;
  logic   rst_n;
  logic   stall;
  logic   redirect_valid;
  addr_t  redirect_target;
  logic   btb_upd_valid;
  addr_t  btb_upd_pc;
  addr_t  btb_upd_target;
  logic   btb_upd_taken;
  logic   imem_we;
  addr_t  imem_waddr;
  instr_t imem_wdata;
  logic   valid_id;
  instr_t instr_id;
  addr_t  pc_id;
  addr_t  pc_plus4_id;
  logic   btb_hit_id;
  logic   btb_pred_taken_id;
  addr_t  btb_target_id;

  fetch_top uut (.*);

  // Memory copy, BTB copy and the expected fetch queue
  instr_t     mem_copy   [`FETCH_IMEM_WORDS];
  logic       ref_valid  [`FETCH_BTB_WAYS][`FETCH_BTB_SETS];
  addr_t      ref_tag    [`FETCH_BTB_WAYS][`FETCH_BTB_SETS];
  addr_t      ref_target [`FETCH_BTB_WAYS][`FETCH_BTB_SETS];
  logic       ref_taken  [`FETCH_BTB_WAYS][`FETCH_BTB_SETS];
  int         ref_rr     [`FETCH_BTB_SETS];
  addr_t      ref_pc;
  logic       held_edge;
  fetch_exp_t exp_q [$];

  integer seed;
  string  test_name;
  int     errors;
  int     test_errors_start;
  int     tests_run;
  int     tests_failed;
  int     checked_count;
  addr_t  seen_pc;
  logic   seen_hit;
  logic   seen_taken;
  addr_t  seen_target;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic int set_of(addr_t a);
    return int'(a[IDX_W+1:2]);
  endfunction

  function automatic addr_t tag_of(addr_t a);
    return a >> (IDX_W + 2);
  endfunction

  function automatic btb_res_t ref_btb_lookup(addr_t a);
    btb_res_t res;
    res = '0;
    for (int w = 0; w < `FETCH_BTB_WAYS; w++) begin
      if (ref_valid[w][set_of(a)] && ref_tag[w][set_of(a)] == tag_of(a)) begin
        res.hit    = 1'b1;
        res.taken  = ref_taken[w][set_of(a)];
        res.target = ref_target[w][set_of(a)];
      end
    end
    return res;
  endfunction

  function automatic addr_t ref_next_pc(addr_t pc, logic redir, addr_t redir_pc,
                                        btb_res_t res);
    if (redir) begin
      return redir_pc;
    end else if (res.hit && res.taken) begin
      return res.target;
    end
    return pc + 32'd4;
  endfunction

  // Matching entry is rewritten, otherwise the set's round-robin victim
  task automatic ref_btb_update(addr_t a, addr_t tgt, logic tkn);
    int s;
    int way;
    s   = set_of(a);
    way = -1;
    for (int w = `FETCH_BTB_WAYS - 1; w >= 0; w--) begin
      if (ref_valid[w][s] && ref_tag[w][s] == tag_of(a)) begin
        way = w;
      end
    end
    if (way < 0) begin
      way       = ref_rr[s];
      ref_rr[s] = (ref_rr[s] + 1) % `FETCH_BTB_WAYS;
    end
    ref_valid[way][s]  = 1'b1;
    ref_tag[way][s]    = tag_of(a);
    ref_target[way][s] = tgt;
    ref_taken[way][s]  = tkn;
  endtask

  task automatic check_addr(string name, addr_t expected, addr_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_instr(string name, instr_t expected, instr_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
      errors++;
    end
  endtask

  // Outputs seen at this edge belong to the fetch accepted on the previous one
  task automatic compare_fetch();
    fetch_exp_t want;
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      if (!valid_id) begin
        $display("Error: %s lost the fetch of pc %h, valid_id stayed low", test_name, want.pc);
        errors++;
      end else begin
        check_addr({test_name, " pc_id"}, want.pc, pc_id);
        check_instr({test_name, " instr_id"}, mem_copy[want.pc[WORD_W+1:2]], instr_id);
        check_addr({test_name, " pc_plus4_id"}, want.pc + 32'd4, pc_plus4_id);
        check_bit({test_name, " btb_hit_id"}, want.btb.hit, btb_hit_id);
        check_bit({test_name, " btb_pred_taken_id"}, want.btb.taken, btb_pred_taken_id);
        if (want.btb.hit) begin
          check_addr({test_name, " btb_target_id"}, want.btb.target, btb_target_id);
        end
        seen_pc     = pc_id;
        seen_hit    = btb_hit_id;
        seen_taken  = btb_pred_taken_id;
        seen_target = btb_target_id;
        checked_count++;
      end
    end else if (valid_id && !held_edge) begin
      $display("Error: %s reported a fetch of pc %h that was flushed", test_name, pc_id);
      errors++;
    end
  endtask

  task automatic model_step();
    btb_res_t   res;
    fetch_exp_t item;
    if (!rst_n) begin
      ref_pc    = `FETCH_RESET_PC;
      held_edge = 1'b0;
      exp_q.delete();
      for (int s = 0; s < `FETCH_BTB_SETS; s++) begin
        ref_rr[s] = 0;
        for (int w = 0; w < `FETCH_BTB_WAYS; w++) begin
          ref_valid[w][s] = 1'b0;
        end
      end
    end else begin
      res       = ref_btb_lookup(ref_pc);
      held_edge = stall && !redirect_valid;
      if (!redirect_valid && !stall) begin
        item.pc  = ref_pc;
        item.btb = res;
        exp_q.push_back(item);
      end
      if (redirect_valid || !stall) begin
        ref_pc = ref_next_pc(ref_pc, redirect_valid, redirect_target, res);
      end
      if (btb_upd_valid) begin
        ref_btb_update(btb_upd_pc, btb_upd_target, btb_upd_taken);
      end
    end
  endtask

  always @(posedge clk) begin
    compare_fetch();
    model_step();
  end

  task automatic load_memory();
    for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
      @(negedge clk);
      imem_we     = 1'b1;
      imem_waddr  = addr_t'(i * 4);
      imem_wdata  = $random(seed);
      mem_copy[i] = imem_wdata;
    end
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  task automatic wait_fetches(int n);
    int goal;
    int cycles;
    goal   = checked_count + n;
    cycles = 0;
    while (checked_count < goal && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (checked_count < goal) begin
      $display("Error: %s timed out waiting for a valid fetch", test_name);
      errors++;
    end
  endtask

  task automatic apply_redirect(addr_t target);
    redirect_valid  = 1'b1;
    redirect_target = target;
    @(negedge clk);
    redirect_valid  = 1'b0;
  endtask

  task automatic send_btb_update(addr_t pc, addr_t target, logic taken);
    btb_upd_valid  = 1'b1;
    btb_upd_pc     = pc;
    btb_upd_target = target;
    btb_upd_taken  = taken;
    @(negedge clk);
    btb_upd_valid  = 1'b0;
  endtask

  task automatic begin_test(string name);
    test_name         = name;
    test_errors_start = errors;
  endtask

  task automatic end_test();
    int n;
    n = errors - test_errors_start;
    tests_run++;
    if (n == 0) begin
      $display("[%s] ok", test_name);
    end else begin
      tests_failed++;
      $display("[%s] FAILED, %0d errors", test_name, n);
    end
  endtask

  task automatic run_stall_hold();
    logic   held_valid;
    instr_t held_instr;
    addr_t  held_pc;
    addr_t  held_pc4;
    begin_test("stall_hold");
    stall      = 1'b1;
    held_valid = valid_id;
    held_instr = instr_id;
    held_pc    = pc_id;
    held_pc4   = pc_plus4_id;
    // Every stalled cycle must show the same IF/ID contents
    repeat (6) begin
      @(negedge clk);
      check_bit("stall_hold valid_id", held_valid, valid_id);
      check_instr("stall_hold instr_id", held_instr, instr_id);
      check_addr("stall_hold pc_id", held_pc, pc_id);
      check_addr("stall_hold pc_plus4_id", held_pc4, pc_plus4_id);
    end
    stall = 1'b0;
    wait_fetches(1);
    check_addr("stall_hold resume pc", held_pc + 32'd4, seen_pc);
    end_test();
  endtask

  task automatic run_btb_predict();
    begin_test("btb_predict");
    send_btb_update(32'h0000_0300, 32'h0000_0080, 1'b1);
    apply_redirect(32'h0000_0300);
    wait_fetches(1);
    check_addr("btb_predict taken pc", 32'h0000_0300, seen_pc);
    check_bit("btb_predict taken hit", 1'b1, seen_hit);
    check_bit("btb_predict taken flag", 1'b1, seen_taken);
    check_addr("btb_predict taken target", 32'h0000_0080, seen_target);
    wait_fetches(1);
    check_addr("btb_predict target pc", 32'h0000_0080, seen_pc);
    // Not-taken entry hits but flow stays sequential
    send_btb_update(32'h0000_0340, 32'h0000_0100, 1'b0);
    apply_redirect(32'h0000_0340);
    wait_fetches(1);
    check_bit("btb_predict not-taken hit", 1'b1, seen_hit);
    check_bit("btb_predict not-taken flag", 1'b0, seen_taken);
    wait_fetches(1);
    check_addr("btb_predict not-taken next pc", 32'h0000_0344, seen_pc);
    end_test();
  endtask

  task automatic run_round_robin();
    begin_test("btb_round_robin");
    // Three tags in set 5 where the third one evicts the first
    send_btb_update(32'h0000_0394, 32'h0000_0040, 1'b0);
    send_btb_update(32'h0000_03b4, 32'h0000_0040, 1'b0);
    send_btb_update(32'h0000_03d4, 32'h0000_0040, 1'b0);
    apply_redirect(32'h0000_0394);
    wait_fetches(1);
    check_bit("btb_round_robin evicted hit", 1'b0, seen_hit);
    apply_redirect(32'h0000_03b4);
    wait_fetches(1);
    check_bit("btb_round_robin second hit", 1'b1, seen_hit);
    apply_redirect(32'h0000_03d4);
    wait_fetches(1);
    check_bit("btb_round_robin third hit", 1'b1, seen_hit);
    end_test();
  endtask

  initial begin
    seed            = 32'hf94d699e;
    rst_n           = 1'b0;
    stall           = 1'b1;
    redirect_valid  = 1'b0;
    redirect_target = '0;
    btb_upd_valid   = 1'b0;
    btb_upd_pc      = '0;
    btb_upd_target  = '0;
    btb_upd_taken   = 1'b0;
    imem_we         = 1'b0;
    imem_waddr      = '0;
    imem_wdata      = '0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    checked_count   = 0;
    test_name       = "reset";

    // Load starts under reset and finishes with fetch still stalled
    fork
      begin
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
      end
      load_memory();
    join

    begin_test("reset_fetch");
    stall = 1'b0;
    wait_fetches(1);
    check_addr("reset_fetch first pc", `FETCH_RESET_PC, seen_pc);
    wait_fetches(7);
    check_addr("reset_fetch eighth pc", `FETCH_RESET_PC + 32'd28, seen_pc);
    end_test();

    run_stall_hold();

    begin_test("redirect");
    apply_redirect(32'h0000_0200);
    wait_fetches(1);
    check_addr("redirect first pc", 32'h0000_0200, seen_pc);
    wait_fetches(1);
    check_addr("redirect second pc", 32'h0000_0204, seen_pc);
    end_test();

    run_btb_predict();
    run_round_robin();

    repeat (3) @(negedge clk);
    errors += uut.u_fetch_assert.fail_count;
    $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+hw
hw/fetch_pkg.sv
hw/btb_way.sv
hw/btb.sv
hw/imem.sv
hw/fetch_stage.sv
hw/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

//--- run.sh
#!/bin/sh
# Build the fetch testbench with Verilator, run it and scan the log

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$LOG"; then
  echo "Failure reported in $LOG"
  exit 1
fi

exit 0
